// ==== hw/scrbd_pkg.sv ====
/* Shared sizes, field codes and payload structs for the NP scoreboard.
   Tag space is fixed at 16 entries and the outstanding count must hold 0..16. */

package scrbd_pkg;

  //----------------------------------------------------------------------
  // Sizes
  localparam int unsigned NUM_TAGS      = 16;
  localparam int unsigned TAG_W         = 4;         // Tag index width
  localparam int unsigned CNT_W         = 5;         // Outstanding count, 0..NUM_TAGS
  localparam int unsigned TIMER_W       = 24;
  localparam int unsigned TIMEOUT_LONG  = 16000000;  // Normal completion timeout
  localparam int unsigned TIMEOUT_SHORT = 8;         // Test mode
  localparam int unsigned NUM_CQS       = 16;

  //----------------------------------------------------------------------
  // Field codes
  localparam logic [1:0] SRC_CQ  = 2'd0;   // CQ non-posted write
  localparam logic [1:0] SRC_ATS = 2'd1;   // ATS translation request
  localparam logic [2:0] STS_SC  = 3'd0;   // Successful completion
  localparam logic [2:0] STS_CA  = 3'd4;   // Completer abort
  localparam logic [9:0] ATS_LEN = 10'd2;  // Only legal nonzero length (DW)

  typedef logic [NUM_TAGS-1:0] tag_vec_t;
  typedef logic [TAG_W-1:0]    tag_t;
  typedef logic [CNT_W-1:0]    cnt_t;
  typedef logic [TIMER_W-1:0]  timer_t;

  // Stored per tag at allocation
  typedef struct packed {
    logic [1:0] src;
    logic [5:0] id;
  } scrbd_entry_t;

  // Inbound completion, header and data in one beat
  typedef struct packed {
    logic [15:0] rid;
    logic [7:0]  tag;
    logic [2:0]  status;
    logic [9:0]  length;
    logic        poison;
    logic [63:0] data;
  } cpl_in_t;

  typedef struct packed {
    logic        timeout;   // Dummy header for an expired timer
    logic        bad_len;
    logic        poison;
    logic [2:0]  status;
    logic [7:0]  tag;
    logic [63:0] data;
  } fifo_hdr_t;

  typedef struct packed {
    logic [5:0]  id;
    logic [63:0] data;
    logic        hdrerror;
    logic        dperror;
  } ats_rsp_t;

  typedef struct packed {
    logic [7:0]       bus;
    logic [CNT_W-1:0] limit;     // Max tags outstanding, 0 blocks allocation
    logic             short_to;  // Select TIMEOUT_SHORT
  } cfg_t;

endpackage

// ==== hw/scrbd_tag_table.sv ====
/* Tag allocator and entry store. Allocating while o_tag_v is low is illegal.
   Entry reads return one cycle after i_rd_en. */
`timescale 1ns/10ps

module scrbd_tag_table (
  input  logic                    prim_nonflr_clk,
  input  logic                    prim_gated_rst_b,
  input  scrbd_pkg::cnt_t         i_limit,
  input  logic                    i_alloc,
  input  scrbd_pkg::scrbd_entry_t i_alloc_entry,
  input  logic                    i_free,
  input  scrbd_pkg::tag_t         i_free_tag,
  input  logic                    i_rd_en,
  input  scrbd_pkg::tag_t         i_rd_tag,
  output logic                    o_tag_v,
  output scrbd_pkg::tag_t         o_tag,
  output logic                    o_np_pending,
  output scrbd_pkg::tag_vec_t     o_timer_start,
  output scrbd_pkg::scrbd_entry_t o_rd_entry
);

  scrbd_pkg::tag_vec_t     inuse_q;
  scrbd_pkg::cnt_t         cnt_q;      // Tags in use
  logic                    tag_any;
  scrbd_pkg::scrbd_entry_t entry_mem [scrbd_pkg::NUM_TAGS];

  // Lowest free tag, scan from the top so the lowest wins
  always_comb begin
    o_tag   = '0;
    tag_any = 1'b0;
    for (int i = scrbd_pkg::NUM_TAGS - 1; i >= 0; i--) begin
      if (!inuse_q[i]) begin
        o_tag   = scrbd_pkg::tag_t'(i);
        tag_any = 1'b1;
      end
    end
  end

  assign o_tag_v       = tag_any & (cnt_q < i_limit);
  assign o_np_pending  = |cnt_q;
  assign o_timer_start = i_alloc ? (scrbd_pkg::tag_vec_t'(1) << o_tag) : '0;

  always_ff @(posedge prim_nonflr_clk or negedge prim_gated_rst_b) begin
    if (!prim_gated_rst_b) begin
      inuse_q <= '0;
      cnt_q   <= '0;
    end else begin
      if (i_alloc) inuse_q[o_tag] <= 1'b1;
      if (i_free)  inuse_q[i_free_tag] <= 1'b0;   // Never the tag being allocated
      case ({i_alloc, i_free})
        2'b10:   cnt_q <= cnt_q + scrbd_pkg::cnt_t'(1);
        2'b01:   cnt_q <= cnt_q - scrbd_pkg::cnt_t'(1);
        default: cnt_q <= cnt_q;                   // Both or neither
      endcase
    end
  end

  // Entry storage in flops
  always_ff @(posedge prim_nonflr_clk) begin
    if (i_alloc) entry_mem[o_tag] <= i_alloc_entry;
    if (i_rd_en) o_rd_entry <= entry_mem[i_rd_tag];
  end

endmodule

// ==== hw/cpl_timer.sv ====
/* One completion timer. Counts from zero after start and expires on reaching
   the selected timeout. Stop wins over expiry in the same cycle. */
`timescale 1ns/10ps

module cpl_timer (
  input  logic prim_nonflr_clk,
  input  logic prim_gated_rst_b,
  input  logic i_start,
  input  logic i_stop,
  input  logic i_short,
  output logic o_running,
  output logic o_expire
);

  scrbd_pkg::timer_t count_q;
  scrbd_pkg::timer_t limit;

  assign limit    = i_short ? scrbd_pkg::timer_t'(scrbd_pkg::TIMEOUT_SHORT)
                            : scrbd_pkg::timer_t'(scrbd_pkg::TIMEOUT_LONG);
  assign o_expire = o_running & ~i_stop & (count_q == limit);

  always_ff @(posedge prim_nonflr_clk or negedge prim_gated_rst_b) begin
    if (!prim_gated_rst_b) begin
      o_running <= 1'b0;
      count_q   <= '0;
    end else if (i_start) begin
      o_running <= 1'b1;                 // Zero on the first running cycle
      count_q   <= '0;
    end else if (i_stop || o_expire) begin
      o_running <= 1'b0;
      count_q   <= '0;
    end else if (o_running) begin
      count_q   <= count_q + scrbd_pkg::timer_t'(1);
    end
  end

endmodule

// ==== hw/cpl_timeout_arb.sv ====
/* Collects timer expiries and offers them one at a time, round robin.
   A granted tag is cleared and the pointer moves past it at the same edge. */
`timescale 1ns/10ps

module cpl_timeout_arb (
  input  logic                prim_nonflr_clk,
  input  logic                prim_gated_rst_b,
  input  scrbd_pkg::tag_vec_t i_expire,
  input  logic                i_grant,
  output logic                o_to_v,
  output scrbd_pkg::tag_t     o_to_tag
);

  scrbd_pkg::tag_vec_t pend_q;   // Expired, not yet pushed
  scrbd_pkg::tag_t     ptr_q;    // Search starts here
  scrbd_pkg::tag_vec_t clr;

  assign o_to_v = |pend_q;

  // First pending tag at or after the pointer
  always_comb begin
    scrbd_pkg::tag_t idx;
    logic            found;
    o_to_tag = ptr_q;
    found    = 1'b0;
    for (int i = 0; i < scrbd_pkg::NUM_TAGS; i++) begin
      idx = ptr_q + scrbd_pkg::tag_t'(i);   // Wraps at NUM_TAGS
      if (pend_q[idx] && !found) begin
        o_to_tag = idx;
        found    = 1'b1;
      end
    end
  end

  assign clr = (i_grant & o_to_v) ? (scrbd_pkg::tag_vec_t'(1) << o_to_tag) : '0;

  always_ff @(posedge prim_nonflr_clk or negedge prim_gated_rst_b) begin
    if (!prim_gated_rst_b) begin
      pend_q <= '0;
      ptr_q  <= '0;
    end else begin
      pend_q <= (pend_q | i_expire) & ~clr;
      if (i_grant && o_to_v) ptr_q <= o_to_tag + scrbd_pkg::tag_t'(1);
    end
  end

endmodule

// ==== hw/cpl_checker.sv ====
/* Inbound completion checks. Inbound traffic always wins the FIFO push slot
   and timeouts fill idle cycles. Error pulses come one cycle after the beat. */
`timescale 1ns/10ps

module cpl_checker (
  input  logic                  prim_nonflr_clk,
  input  logic                  prim_gated_rst_b,
  input  logic [7:0]            i_bus,
  input  logic                  i_cpl_v,
  input  scrbd_pkg::cpl_in_t    i_cpl,
  input  scrbd_pkg::tag_vec_t   i_running,
  input  logic                  i_to_v,
  input  scrbd_pkg::tag_t       i_to_tag,
  output logic                  o_to_grant,
  output scrbd_pkg::tag_vec_t   o_timer_stop,
  output logic                  o_push,
  output scrbd_pkg::fifo_hdr_t  o_push_hdr,
  output logic                  o_cpl_unexpected,
  output logic                  o_cpl_abort,
  output logic                  o_cpl_ur,
  output logic                  o_cpl_poisoned,
  output scrbd_pkg::cpl_in_t    o_error_hdr
);

  logic rid_ok;     // Addressed to our function {bus, 0}
  logic tag_live;   // Tag in range with a running timer
  logic unexp_d, abort_d, ur_d, pois_d;

  assign rid_ok   = (i_cpl.rid == {i_bus, 8'd0});
  assign tag_live = (i_cpl.tag[7:scrbd_pkg::TAG_W] == '0) &
                    i_running[i_cpl.tag[scrbd_pkg::TAG_W-1:0]];

  always_comb begin
    o_push       = 1'b0;
    o_to_grant   = 1'b0;
    o_timer_stop = '0;
    unexp_d      = 1'b0;
    abort_d      = 1'b0;
    ur_d         = 1'b0;
    pois_d       = 1'b0;
    o_push_hdr   = '{timeout: 1'b0, bad_len: 1'b0, poison: i_cpl.poison,
                     status: i_cpl.status, tag: i_cpl.tag, data: i_cpl.data};
    if (i_cpl_v) begin
      if (rid_ok && tag_live) begin
        o_push = 1'b1;
        o_timer_stop[i_cpl.tag[scrbd_pkg::TAG_W-1:0]] = 1'b1;
        if ((i_cpl.length != 10'd0) && (i_cpl.length != scrbd_pkg::ATS_LEN)) begin
          o_push_hdr.bad_len = 1'b1;   // Still pushed so the requester sees it
          unexp_d            = 1'b1;
        end else if (i_cpl.status == scrbd_pkg::STS_CA) begin
          abort_d = 1'b1;
        end else if (i_cpl.status != scrbd_pkg::STS_SC) begin
          ur_d    = 1'b1;
        end else begin
          pois_d  = i_cpl.poison;
        end
      end else begin
        unexp_d = 1'b1;                // Dropped, nothing pushed
      end
    end else if (i_to_v) begin
      // Dummy header for an expired tag
      o_push          = 1'b1;
      o_to_grant      = 1'b1;
      o_push_hdr      = '0;
      o_push_hdr.timeout = 1'b1;
      o_push_hdr.tag  = 8'(i_to_tag);
    end
  end

  //----------------------------------------------------------------------
  // Error pulses and captured header
  always_ff @(posedge prim_nonflr_clk or negedge prim_gated_rst_b) begin
    if (!prim_gated_rst_b) begin
      o_cpl_unexpected <= 1'b0;
      o_cpl_abort      <= 1'b0;
      o_cpl_ur         <= 1'b0;
      o_cpl_poisoned   <= 1'b0;
    end else begin
      o_cpl_unexpected <= unexp_d;
      o_cpl_abort      <= abort_d;
      o_cpl_ur         <= ur_d;
      o_cpl_poisoned   <= pois_d;
    end
  end

  always_ff @(posedge prim_nonflr_clk) begin
    if (unexp_d || abort_d || ur_d || pois_d) o_error_hdr <= i_cpl;
  end

endmodule

// ==== hw/cpl_hdr_fifo.sv ====
/* Header FIFO, NUM_TAGS deep. Never overflows since each tag pushes at most
   one header. Pop is ignored while empty. */
`timescale 1ns/10ps

module cpl_hdr_fifo (
  input  logic                 prim_nonflr_clk,
  input  logic                 prim_gated_rst_b,
  input  logic                 i_push,
  input  scrbd_pkg::fifo_hdr_t i_push_hdr,
  input  logic                 i_pop,
  output logic                 o_pop_v,
  output scrbd_pkg::fifo_hdr_t o_pop_hdr
);

  scrbd_pkg::fifo_hdr_t mem [scrbd_pkg::NUM_TAGS];
  scrbd_pkg::tag_t      rd_ptr_q;
  scrbd_pkg::cnt_t      cnt_q;       // Entries held, 0..NUM_TAGS
  scrbd_pkg::tag_t      wr_ptr;
  logic                 pop_go;

  assign wr_ptr    = rd_ptr_q + cnt_q[scrbd_pkg::TAG_W-1:0];
  assign o_pop_v   = (cnt_q != '0);
  assign o_pop_hdr = mem[rd_ptr_q];
  assign pop_go    = i_pop & o_pop_v;

  always_ff @(posedge prim_nonflr_clk or negedge prim_gated_rst_b) begin
    if (!prim_gated_rst_b) begin
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (pop_go) rd_ptr_q <= rd_ptr_q + scrbd_pkg::tag_t'(1);
      case ({i_push, pop_go})
        2'b10:   cnt_q <= cnt_q + scrbd_pkg::cnt_t'(1);
        2'b01:   cnt_q <= cnt_q - scrbd_pkg::cnt_t'(1);
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  always_ff @(posedge prim_nonflr_clk) begin
    if (i_push) mem[wr_ptr] <= i_push_hdr;
  end

endmodule

// ==== hw/cpl_processor.sv ====
/* Two stages. Stage 1 pops the FIFO and reads the entry by tag, stage 2 routes
   by source and frees the tag. Outputs are registered after stage 2. */
`timescale 1ns/10ps

module cpl_processor (
  input  logic                         prim_nonflr_clk,
  input  logic                         prim_gated_rst_b,
  input  logic                         i_pop_v,
  input  scrbd_pkg::fifo_hdr_t         i_pop_hdr,
  input  scrbd_pkg::scrbd_entry_t      i_rd_entry,
  output logic                         o_pop,
  output logic                         o_rd_en,
  output scrbd_pkg::tag_t              o_rd_tag,
  output logic                         o_free,
  output scrbd_pkg::tag_t              o_free_tag,
  output logic                         o_ats_rsp_v,
  output scrbd_pkg::ats_rsp_t          o_ats_rsp,
  output logic [scrbd_pkg::NUM_CQS-1:0] o_cq_np_dec,
  output logic                         o_cpl_timeout,
  output scrbd_pkg::scrbd_entry_t      o_cpl_timeout_synd
);

  logic                 s2_v_q;
  scrbd_pkg::fifo_hdr_t s2_hdr_q;
  logic                 hdr_err;     // Timeout, bad length, CA or UR
  logic                 is_ats;
  logic                 is_cq;

  // Stage 1, pop and read together
  assign o_pop    = i_pop_v;
  assign o_rd_en  = i_pop_v;
  assign o_rd_tag = i_pop_hdr.tag[scrbd_pkg::TAG_W-1:0];

  always_ff @(posedge prim_nonflr_clk or negedge prim_gated_rst_b) begin
    if (!prim_gated_rst_b) s2_v_q <= 1'b0;
    else                   s2_v_q <= i_pop_v;
  end

  always_ff @(posedge prim_nonflr_clk) begin
    if (i_pop_v) s2_hdr_q <= i_pop_hdr;
  end

  //----------------------------------------------------------------------
  // Stage 2, entry is valid now
  assign hdr_err    = s2_hdr_q.timeout | s2_hdr_q.bad_len |
                      (s2_hdr_q.status != scrbd_pkg::STS_SC);
  assign is_ats     = s2_v_q & (i_rd_entry.src == scrbd_pkg::SRC_ATS);
  assign is_cq      = s2_v_q & (i_rd_entry.src == scrbd_pkg::SRC_CQ);
  assign o_free     = s2_v_q;                               // Done with the tag
  assign o_free_tag = s2_hdr_q.tag[scrbd_pkg::TAG_W-1:0];

  always_ff @(posedge prim_nonflr_clk or negedge prim_gated_rst_b) begin
    if (!prim_gated_rst_b) begin
      o_ats_rsp_v   <= 1'b0;
      o_cq_np_dec   <= '0;
      o_cpl_timeout <= 1'b0;
    end else begin
      o_ats_rsp_v   <= is_ats;
      o_cq_np_dec   <= is_cq ? (scrbd_pkg::NUM_CQS'(1) << i_rd_entry.id[3:0]) : '0;
      o_cpl_timeout <= s2_v_q & s2_hdr_q.timeout;
    end
  end

  always_ff @(posedge prim_nonflr_clk) begin
    if (is_ats) begin
      o_ats_rsp.id       <= i_rd_entry.id;
      o_ats_rsp.data     <= hdr_err ? 64'd0 : s2_hdr_q.data;   // No data on header errors
      o_ats_rsp.hdrerror <= hdr_err;
      o_ats_rsp.dperror  <= s2_hdr_q.poison & ~hdr_err;
    end
    if (s2_v_q && s2_hdr_q.timeout) o_cpl_timeout_synd <= i_rd_entry;  // Syndrome
  end

endmodule

// ==== hw/np_scrbd_top.sv ====
/* Non-posted request scoreboard. All transfers are single-cycle pulses with
   no back-pressure. Response latency is three cycles with an empty FIFO. */
`timescale 1ns/10ps

module np_scrbd_top (
  input  logic                          prim_nonflr_clk,
  input  logic                          prim_gated_rst_b,
  input  scrbd_pkg::cfg_t               i_cfg,
  input  logic                          i_alloc,
  input  scrbd_pkg::scrbd_entry_t       i_alloc_entry,
  input  logic                          i_cpl_v,
  input  scrbd_pkg::cpl_in_t            i_cpl,
  output logic                          o_tag_v,
  output scrbd_pkg::tag_t               o_tag,
  output logic                          o_np_pending,
  output logic                          o_ats_rsp_v,
  output scrbd_pkg::ats_rsp_t           o_ats_rsp,
  output logic [scrbd_pkg::NUM_CQS-1:0] o_cq_np_dec,
  output logic                          o_cpl_unexpected,
  output logic                          o_cpl_abort,
  output logic                          o_cpl_ur,
  output logic                          o_cpl_poisoned,
  output scrbd_pkg::cpl_in_t            o_cpl_error_hdr,
  output logic                          o_cpl_timeout,
  output scrbd_pkg::scrbd_entry_t       o_cpl_timeout_synd
);

  scrbd_pkg::tag_vec_t     timer_start, timer_stop, timer_running, timer_expire;
  logic                    to_v, to_grant;
  scrbd_pkg::tag_t         to_tag;
  logic                    push, pop, pop_v;
  scrbd_pkg::fifo_hdr_t    push_hdr, pop_hdr;
  logic                    rd_en, free;
  scrbd_pkg::tag_t         rd_tag, free_tag;
  scrbd_pkg::scrbd_entry_t rd_entry;

  scrbd_tag_table u_tag_table (
    .prim_nonflr_clk, .prim_gated_rst_b,
    .i_limit (i_cfg.limit), .i_alloc, .i_alloc_entry,
    .i_free (free), .i_free_tag (free_tag), .i_rd_en (rd_en), .i_rd_tag (rd_tag),
    .o_tag_v, .o_tag, .o_np_pending,
    .o_timer_start (timer_start), .o_rd_entry (rd_entry)
  );

  //----------------------------------------------------------------------
  // One timer per tag
  for (genvar g = 0; g < scrbd_pkg::NUM_TAGS; g++) begin : g_timer
    cpl_timer u_timer (
      .prim_nonflr_clk, .prim_gated_rst_b,
      .i_start (timer_start[g]), .i_stop (timer_stop[g]), .i_short (i_cfg.short_to),
      .o_running (timer_running[g]), .o_expire (timer_expire[g])
    );
  end

  cpl_timeout_arb u_timeout_arb (
    .prim_nonflr_clk, .prim_gated_rst_b,
    .i_expire (timer_expire), .i_grant (to_grant),
    .o_to_v (to_v), .o_to_tag (to_tag)
  );

  cpl_checker u_checker (
    .prim_nonflr_clk, .prim_gated_rst_b,
    .i_bus (i_cfg.bus), .i_cpl_v, .i_cpl, .i_running (timer_running),
    .i_to_v (to_v), .i_to_tag (to_tag),
    .o_to_grant (to_grant), .o_timer_stop (timer_stop),
    .o_push (push), .o_push_hdr (push_hdr),
    .o_cpl_unexpected, .o_cpl_abort, .o_cpl_ur, .o_cpl_poisoned,
    .o_error_hdr (o_cpl_error_hdr)
  );

  cpl_hdr_fifo u_hdr_fifo (
    .prim_nonflr_clk, .prim_gated_rst_b,
    .i_push (push), .i_push_hdr (push_hdr), .i_pop (pop),
    .o_pop_v (pop_v), .o_pop_hdr (pop_hdr)
  );

  cpl_processor u_processor (
    .prim_nonflr_clk, .prim_gated_rst_b,
    .i_pop_v (pop_v), .i_pop_hdr (pop_hdr), .i_rd_entry (rd_entry),
    .o_pop (pop), .o_rd_en (rd_en), .o_rd_tag (rd_tag),
    .o_free (free), .o_free_tag (free_tag),
    .o_ats_rsp_v, .o_ats_rsp, .o_cq_np_dec, .o_cpl_timeout, .o_cpl_timeout_synd
  );

endmodule

// ==== sim/np_scrbd_sva.sv ====
/* Concurrent checks bound into the scoreboard top level. All are off in reset. */
`timescale 1ns/10ps

module np_scrbd_sva (
  input logic prim_nonflr_clk,
  input logic prim_gated_rst_b,
  input logic i_alloc,
  input logic i_tag_v,
  input logic i_ats_rsp_v,
  input logic i_cpl_timeout,
  input logic i_cpl_unexpected,
  input logic i_cpl_abort,
  input logic i_cpl_ur,
  input logic i_cpl_poisoned
);

  // Allocation only against an offered tag
  a_alloc_with_tag : assert property (
    @(posedge prim_nonflr_clk) disable iff (!prim_gated_rst_b) i_alloc |-> i_tag_v)
    else $error("allocation while no tag is offered");

  a_rsp_known : assert property (
    @(posedge prim_nonflr_clk) disable iff (!prim_gated_rst_b)
    !$isunknown({i_ats_rsp_v, i_cpl_timeout}))
    else $error("response valid is unknown");

  //----------------------------------------------------------------------
  // Error flags are single-cycle pulses
  a_unexp_pulse : assert property (
    @(posedge prim_nonflr_clk) disable iff (!prim_gated_rst_b)
    i_cpl_unexpected |=> !i_cpl_unexpected) else $error("unexpected flag held");
  a_abort_pulse : assert property (
    @(posedge prim_nonflr_clk) disable iff (!prim_gated_rst_b)
    i_cpl_abort |=> !i_cpl_abort) else $error("abort flag held");
  a_ur_pulse : assert property (
    @(posedge prim_nonflr_clk) disable iff (!prim_gated_rst_b)
    i_cpl_ur |=> !i_cpl_ur) else $error("UR flag held");
  a_pois_pulse : assert property (
    @(posedge prim_nonflr_clk) disable iff (!prim_gated_rst_b)
    i_cpl_poisoned |=> !i_cpl_poisoned) else $error("poisoned flag held");

endmodule

bind np_scrbd_top np_scrbd_sva u_sva (
  .prim_nonflr_clk  (prim_nonflr_clk),
  .prim_gated_rst_b (prim_gated_rst_b),
  .i_alloc          (i_alloc),
  .i_tag_v          (o_tag_v),
  .i_ats_rsp_v      (o_ats_rsp_v),
  .i_cpl_timeout    (o_cpl_timeout),
  .i_cpl_unexpected (o_cpl_unexpected),
  .i_cpl_abort      (o_cpl_abort),
  .i_cpl_ur         (o_cpl_ur),
  .i_cpl_poisoned   (o_cpl_poisoned)
);

// ==== sim/np_scrbd_tb.sv ====
/* Directed testbench for the NP scoreboard. Runs with bus 3Ah, limit 4 and the
   short timeout. Each row waits for all tags to drain before the next starts. */
`timescale 1ns/10ps

module np_scrbd_tb;

  localparam int         RSP_WAIT  = 40;    // Covers a short timeout plus reporting
  localparam int         IDLE_WAIT = 60;
  localparam int         NUM_ROWS  = 10;
  localparam logic [1:0] RSP_NONE  = 2'd0;
  localparam logic [1:0] RSP_ATS   = 2'd1;
  localparam logic [1:0] RSP_CQ    = 2'd2;
  localparam logic [2:0] ERR_NONE  = 3'd0;
  localparam logic [2:0] ERR_UNEXP = 3'd1;
  localparam logic [2:0] ERR_ABORT = 3'd2;
  localparam logic [2:0] ERR_UR    = 3'd3;
  localparam logic [2:0] ERR_POIS  = 3'd4;

  typedef struct packed {
    logic        alloc;       // Allocate a tag first
    logic        send_cpl;
    logic [1:0]  src;
    logic [5:0]  id;
    logic [7:0]  tag_off;     // Added to the offered tag
    logic [15:0] rid_xor;     // Nonzero gives a wrong requester id
    logic [2:0]  status;
    logic [9:0]  length;
    logic        poison;
    logic [1:0]  exp_rsp;     // Response to the completion
    logic [2:0]  exp_err;     // Error pulse one cycle after it
    logic        exp_hdrerr;
    logic        exp_dperr;
    logic        exp_to;      // Timeout report follows
  } stim_row_t;

  logic                          prim_nonflr_clk = 1'b0;
  logic                          prim_gated_rst_b;
  scrbd_pkg::cfg_t               i_cfg;
  logic                          i_alloc;
  scrbd_pkg::scrbd_entry_t       i_alloc_entry;
  logic                          i_cpl_v;
  scrbd_pkg::cpl_in_t            i_cpl;
  logic                          o_tag_v;
  scrbd_pkg::tag_t               o_tag;
  logic                          o_np_pending;
  logic                          o_ats_rsp_v;
  scrbd_pkg::ats_rsp_t           o_ats_rsp;
  logic [scrbd_pkg::NUM_CQS-1:0] o_cq_np_dec;
  logic                          o_cpl_unexpected;
  logic                          o_cpl_abort;
  logic                          o_cpl_ur;
  logic                          o_cpl_poisoned;
  scrbd_pkg::cpl_in_t            o_cpl_error_hdr;
  logic                          o_cpl_timeout;
  scrbd_pkg::scrbd_entry_t       o_cpl_timeout_synd;

  stim_row_t rows [NUM_ROWS];
  string     names [NUM_ROWS] = '{"good_ats", "status_ca", "status_ur", "bad_length",
                                  "poisoned", "wrong_rid", "unalloc_tag", "cq_decrement",
                                  "timeout_ats", "timeout_cq"};
  string     cur_test;
  int        seed;
  int        err_cnt;
  int        tests_run;
  int        tests_bad;

  np_scrbd_top DUT (.*);

  always #5 prim_nonflr_clk = ~prim_nonflr_clk;   // 10 ns

  //----------------------------------------------------------------------
  // Helpers
  task automatic expect_true(input logic cond, input string msg);
    assert (cond) else begin
      $display("FAIL %0t: %s: %s", $time, cur_test, msg);
      err_cnt++;
    end
  endtask

  task automatic wait_response(output logic seen);
    int n;
    n    = 0;
    seen = 1'b0;
    while (!seen && n < RSP_WAIT) begin
      @(negedge prim_nonflr_clk);
      n++;
      seen = o_ats_rsp_v | (|o_cq_np_dec) | o_cpl_timeout;
    end
    if (!seen) begin
      $display("Timeout in %s: no response from the DUT after %0d cycles", cur_test, RSP_WAIT);
      err_cnt++;
    end
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    while (o_np_pending && n < IDLE_WAIT) begin
      @(negedge prim_nonflr_clk);
      n++;
    end
    if (o_np_pending) begin
      $display("Timeout in %s: tags still outstanding after %0d cycles", cur_test, IDLE_WAIT);
      err_cnt++;
    end
  endtask

  task automatic report_test(input int errs_before);
    tests_run++;
    if (err_cnt != errs_before) tests_bad++;
    $display("Test %0d %s: %s", tests_run, cur_test, (err_cnt == errs_before) ? "ok" : "errors");
  endtask

  task automatic load_table();
    rows[0] = '{1'b1, 1'b1, scrbd_pkg::SRC_ATS, 6'h11, 8'h00, 16'h0000, scrbd_pkg::STS_SC,
                10'd2, 1'b0, RSP_ATS, ERR_NONE, 1'b0, 1'b0, 1'b0};
    rows[1] = '{1'b1, 1'b1, scrbd_pkg::SRC_ATS, 6'h22, 8'h00, 16'h0000, scrbd_pkg::STS_CA,
                10'd2, 1'b0, RSP_ATS, ERR_ABORT, 1'b1, 1'b0, 1'b0};
    rows[2] = '{1'b1, 1'b1, scrbd_pkg::SRC_ATS, 6'h23, 8'h00, 16'h0000, 3'd1,
                10'd2, 1'b0, RSP_ATS, ERR_UR, 1'b1, 1'b0, 1'b0};
    rows[3] = '{1'b1, 1'b1, scrbd_pkg::SRC_ATS, 6'h24, 8'h00, 16'h0000, scrbd_pkg::STS_SC,
                10'd5, 1'b0, RSP_ATS, ERR_UNEXP, 1'b1, 1'b0, 1'b0};
    rows[4] = '{1'b1, 1'b1, scrbd_pkg::SRC_ATS, 6'h25, 8'h00, 16'h0000, scrbd_pkg::STS_SC,
                10'd2, 1'b1, RSP_ATS, ERR_POIS, 1'b0, 1'b1, 1'b0};
    // Dropped, so its timer runs out later
    rows[5] = '{1'b1, 1'b1, scrbd_pkg::SRC_ATS, 6'h26, 8'h00, 16'h0001, scrbd_pkg::STS_SC,
                10'd2, 1'b0, RSP_NONE, ERR_UNEXP, 1'b0, 1'b0, 1'b1};
    rows[6] = '{1'b0, 1'b1, scrbd_pkg::SRC_CQ, 6'h00, 8'h03, 16'h0000, scrbd_pkg::STS_SC,
                10'd2, 1'b0, RSP_NONE, ERR_UNEXP, 1'b0, 1'b0, 1'b0};
    rows[7] = '{1'b1, 1'b1, scrbd_pkg::SRC_CQ, 6'h2B, 8'h00, 16'h0000, scrbd_pkg::STS_SC,
                10'd0, 1'b0, RSP_CQ, ERR_NONE, 1'b0, 1'b0, 1'b0};
    rows[8] = '{1'b1, 1'b0, scrbd_pkg::SRC_ATS, 6'h31, 8'h00, 16'h0000, scrbd_pkg::STS_SC,
                10'd0, 1'b0, RSP_NONE, ERR_NONE, 1'b0, 1'b0, 1'b1};
    rows[9] = '{1'b1, 1'b0, scrbd_pkg::SRC_CQ, 6'h1C, 8'h00, 16'h0000, scrbd_pkg::STS_SC,
                10'd0, 1'b0, RSP_NONE, ERR_NONE, 1'b0, 1'b0, 1'b1};
  endtask

  //----------------------------------------------------------------------
  // Allocation limit, all four left to time out
  task automatic run_alloc_limit();
    int   errs_before;
    logic seen;
    errs_before = err_cnt;
    cur_test    = "alloc_limit";
    expect_true(!o_ats_rsp_v && !o_cpl_timeout && o_cq_np_dec == '0, "response after reset");
    expect_true(!(o_cpl_unexpected | o_cpl_abort | o_cpl_ur | o_cpl_poisoned),
                "error pulse after reset");
    expect_true(o_tag_v && !o_np_pending, "tag state after reset");
    for (int k = 0; k < 4; k++) begin
      expect_true(o_tag_v, "no tag offered below the limit");
      expect_true(o_tag == scrbd_pkg::tag_t'(k), "offered tag is not the lowest free");
      i_alloc       = o_tag_v;
      i_alloc_entry = '{src: scrbd_pkg::SRC_CQ, id: 6'(k)};
      @(negedge prim_nonflr_clk);
      i_alloc       = 1'b0;
    end
    expect_true(!o_tag_v, "o_tag_v still high at the limit");
    expect_true(o_np_pending, "o_np_pending low with tags out");
    wait_response(seen);
    if (seen) begin
      // Tag 0 started first, so it is the first to time out
      expect_true(o_cpl_timeout, "first report is not a timeout");
      expect_true(o_tag_v, "o_tag_v not back after a free");   // Free landed at this edge
      expect_true(o_tag == '0, "freed tag 0 not offered again");
      expect_true(o_cpl_timeout_synd.src == scrbd_pkg::SRC_CQ &&
                  o_cpl_timeout_synd.id == 6'd0, "timeout syndrome");
      expect_true(o_cq_np_dec == 16'h0001, "CQ decrement");
    end
    wait_idle();
    report_test(errs_before);
  endtask

  //----------------------------------------------------------------------
  // One table row
  task automatic run_row(input int idx);
    stim_row_t               r;
    scrbd_pkg::scrbd_entry_t ent;
    scrbd_pkg::cpl_in_t      cpl;
    logic                    seen;
    int                      errs_before;
    r           = rows[idx];
    errs_before = err_cnt;
    cur_test    = names[idx];
    ent         = '{src: r.src, id: r.id};
    cpl = '{rid: {i_cfg.bus, 8'h00} ^ r.rid_xor, tag: {4'd0, o_tag} + r.tag_off,
            status: r.status, length: r.length, poison: r.poison,
            data: {$random(seed), $random(seed)}};
    if (r.alloc) begin
      expect_true(o_tag_v, "no tag offered with the scoreboard idle");
      i_alloc       = o_tag_v;
      i_alloc_entry = ent;
      @(negedge prim_nonflr_clk);
      i_alloc       = 1'b0;
    end
    if (r.send_cpl) begin
      i_cpl   = cpl;
      i_cpl_v = 1'b1;
      @(negedge prim_nonflr_clk);
      i_cpl_v = 1'b0;
      // Error pulses one cycle after the beat
      expect_true(o_cpl_unexpected == (r.exp_err == ERR_UNEXP), "unexpected flag");
      expect_true(o_cpl_abort == (r.exp_err == ERR_ABORT), "abort flag");
      expect_true(o_cpl_ur == (r.exp_err == ERR_UR), "UR flag");
      expect_true(o_cpl_poisoned == (r.exp_err == ERR_POIS), "poisoned flag");
      if (r.exp_err != ERR_NONE) expect_true(o_cpl_error_hdr == cpl, "error header");
      if (r.exp_rsp == RSP_NONE) begin
        for (int n = 0; n < 5; n++) begin    // Well short of the timer
          @(negedge prim_nonflr_clk);
          expect_true(!o_ats_rsp_v && o_cq_np_dec == '0 && !o_cpl_timeout,
                      "response to a dropped completion");
        end
      end else begin
        wait_response(seen);
        if (seen && r.exp_rsp == RSP_ATS) begin
          expect_true(o_ats_rsp_v && !o_cpl_timeout && o_cq_np_dec == '0, "not an ATS response");
          expect_true(o_ats_rsp.id == r.id, "ATS response id");
          expect_true(o_ats_rsp.hdrerror == r.exp_hdrerr, "ATS header error bit");
          expect_true(o_ats_rsp.dperror == r.exp_dperr, "ATS data error bit");
          expect_true(o_ats_rsp.data == (r.exp_hdrerr ? 64'd0 : cpl.data), "ATS data");
        end else if (seen) begin
          // Bit is id mod 16
          expect_true(o_cq_np_dec == (16'(1) << r.id[3:0]) && !o_ats_rsp_v, "CQ decrement");
        end
      end
    end
    if (r.exp_to) begin
      wait_response(seen);
      if (seen) begin
        expect_true(o_cpl_timeout, "no timeout report");
        expect_true(o_cpl_timeout_synd == ent, "timeout syndrome");
        if (r.src == scrbd_pkg::SRC_ATS) begin
          // Timeout is a header error without data
          expect_true(o_ats_rsp_v && o_ats_rsp.id == r.id, "no ATS response on timeout");
          expect_true(o_ats_rsp.hdrerror && !o_ats_rsp.dperror && o_ats_rsp.data == '0,
                      "ATS timeout response fields");
        end else begin
          expect_true(o_cq_np_dec == (16'(1) << r.id[3:0]), "CQ decrement on timeout");
        end
      end
    end
    wait_idle();
    report_test(errs_before);
  endtask

  //----------------------------------------------------------------------
  initial begin
    seed             = 74033;
    err_cnt          = 0;
    tests_run        = 0;
    tests_bad        = 0;
    prim_gated_rst_b = 1'b0;
    i_cfg            = '{bus: 8'h3A, limit: 5'd4, short_to: 1'b1};
    i_alloc          = 1'b0;
    i_alloc_entry    = '0;
    i_cpl_v          = 1'b0;
    i_cpl            = '0;
    load_table();
    repeat (8) @(posedge prim_nonflr_clk);
    @(negedge prim_nonflr_clk);
    prim_gated_rst_b = 1'b1;
    run_alloc_limit();
    for (int i = 0; i < NUM_ROWS; i++) run_row(i);
    $display("Tests run %0d, tests with errors %0d, failed checks %0d",
             tests_run, tests_bad, err_cnt);
    if (err_cnt == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// ==== sim.f ====
hw/scrbd_pkg.sv
hw/scrbd_tag_table.sv
hw/cpl_timer.sv
hw/cpl_timeout_arb.sv
hw/cpl_checker.sv
hw/cpl_hdr_fifo.sv
hw/cpl_processor.sv
hw/np_scrbd_top.sv
sim/np_scrbd_sva.sv
sim/np_scrbd_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the NP scoreboard testbench with Verilator, verdict from the log
cd "$(dirname "$0")" || exit 1
LOG=sim.log
rm -rf obj_dir "$LOG"
verilator --binary --timing --assert -f sim.f --top-module np_scrbd_tb \
  -o np_scrbd_sim > "$LOG" 2>&1 \
  && ./obj_dir/np_scrbd_sim >> "$LOG" 2>&1 \
  || { cat "$LOG"; echo "Build or simulation aborted, see $LOG"; exit 1; }
cat "$LOG"
grep -q "Testbench failed" "$LOG" && { echo "Simulation reported errors"; exit 1; }
grep -q "Testbench passed" "$LOG" || { echo "No verdict found in $LOG"; exit 1; }
exit 0
